// ==== cl_dram_scrb_top.f ====
+incdir+.
cl_dram_pkg.sv
cl_scrb_ctl.sv
ddr_scrubber.sv
cl_scrb_status.sv
cl_dram_scrb_top.sv
cl_dram_scrb_checker.sv
tb_cl_dram_scrb.sv

// ==== Bender.yml ====
package:
  name: cl_dram_scrb

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cl_dram_pkg.sv
      - cl_scrb_ctl.sv
      - ddr_scrubber.sv
      - cl_scrb_status.sv
      - cl_dram_scrb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cl_dram_scrb_checker.sv
      - tb_cl_dram_scrb.sv

// ==== tb_cl_dram_scrb.sv ====
`include "cl_dram_defines.svh"

module tb_cl_dram_scrb;

   // Longest run is under 700 cycles
   localparam int          TIMEOUT_CYCLES  = 2000;
   localparam logic [2:0]  ST_IDLE = 3'd0;
   localparam logic [2:0]  ST_RUN  = 3'd1;
   localparam logic [2:0]  ST_DONE = 3'd2;
   localparam logic [63:0] STEP    = (`SCRB_BURST_LEN_MINUS1 + 1) * 64;
   // Falling edges from the enable write until the done flags show:
   // control register, run entry, the bursts, done state and status register
   localparam int          DONE_WAIT = int'((`SCRB_MAX_ADDR + 1) / STEP) + 4;

   logic             clk;
   logic             sync_rst_n;
   logic [31:0]      ctl0;
   logic [3:0]       ddr_is_ready;
   logic             flr_assert;
   logic [31:0]      status0;
   logic [31:0]      status1;
   logic [31:0]      id0;
   logic [31:0]      id1;
   logic             flr_done;

   // Reference model registers
   logic             m_dbg_en;
   logic [2:0]       m_sel;
   logic [3:0]       m_en;
   logic [3:0]       m_ready;
   logic [3:0][2:0]  m_state;
   logic [3:0][63:0] m_addr;
   logic [3:0]       m_done;
   logic             m_flr_q;
   logic [31:0]      exp_status0;
   logic [31:0]      exp_id0;
   logic [31:0]      exp_id1;
   logic             exp_flr_done;
   int               cycle_cnt;

   cl_dram_scrb_top u_dut
   (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .status0      (status0),
      .status1      (status1),
      .id0          (id0),
      .id1          (id1),
      .flr_done     (flr_done)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Simulation FAILED");
      $fatal(1, "Run stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] exp);
      if (act !== exp)
      begin
         fail_run($sformatf("Mismatch %s: expected 0x%0h, got 0x%0h", name, exp, act));
      end
   endtask

   // Expected {status0, id1, id0} from the registered control and channel state
   function automatic logic [95:0] ref_outputs(input logic dbg_en, input logic [2:0] sel,
                                               input logic [3:0][2:0] st,
                                               input logic [3:0][63:0] addr,
                                               input logic [3:0] done, input logic [3:0] ready);
      logic [31:0] s0;
      logic [63:0] ids;
      int          idx;
      idx = (sel >= 3'd1 && sel <= 3'd3) ? int'(sel) : 0;
      if (dbg_en)
      begin
         s0  = {1'b0, st[3], 1'b0, st[2], 1'b0, st[1], 1'b0, st[0], 8'd0, done, ready};
         ids = addr[idx];
      end
      else
      begin
         s0  = {20'ha1111, 4'd0, done, ready};
         ids = {`CL_ID1, `CL_ID0};
      end
      return {s0, ids};
   endfunction

   // -------------------------------------------------------------------------
   // Cycle model of control, scrubbers and FLR response
   // -------------------------------------------------------------------------
   always @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         {m_dbg_en, m_sel, m_en, m_ready, m_done, m_flr_q} <= '0;
         m_state      <= {4{ST_IDLE}};
         m_addr       <= '0;
         exp_status0  <= '0;
         exp_id0      <= '0;
         exp_id1      <= '0;
         exp_flr_done <= 1'b0;
      end
      else
      begin
         {exp_status0, exp_id1, exp_id0} <=
            ref_outputs(m_dbg_en, m_sel, m_state, m_addr, m_done, m_ready);
         m_dbg_en <= ctl0[31];
         m_sel    <= ctl0[30:28];
         m_en     <= ctl0[3:0];
         m_ready  <= ddr_is_ready;
         for (int c = 0; c < 4; c++)
         begin
            if (!m_en[c])
            begin
               m_state[c] <= ST_IDLE;
               m_addr[c]  <= '0;
               m_done[c]  <= 1'b0;
            end
            else if (m_state[c] == ST_IDLE)
            begin
               m_state[c] <= ST_RUN;
               m_addr[c]  <= '0;
            end
            else if (m_state[c] == ST_RUN && m_addr[c] + STEP > `SCRB_MAX_ADDR)
            begin
               m_state[c] <= ST_DONE;
               m_done[c]  <= 1'b1;
            end
            else if (m_state[c] == ST_RUN)
            begin
               m_addr[c] <= m_addr[c] + STEP;
            end
         end
         m_flr_q      <= flr_assert;
         exp_flr_done <= m_flr_q && !exp_flr_done;
      end
   end

   // Compare on the falling edge, away from register updates
   initial
   begin
      forever
      begin
         @(negedge clk);
         check_value("status0", status0, exp_status0);
         check_value("status1", status1, `CL_VERSION);
         check_value("id0", id0, exp_id0);
         check_value("id1", id1, exp_id1);
         check_value("flr_done", flr_done, exp_flr_done);
      end
   end

   initial
   begin
      cycle_cnt = 0;
      forever
      begin
         @(posedge clk);
         cycle_cnt++;
         if (cycle_cnt >= TIMEOUT_CYCLES)
         begin
            fail_run("Timeout: the test sequence did not finish in time");
         end
      end
   end

   task automatic wait_done_flags(input logic [3:0] mask, output int cycles);
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (status0[7:4] !== mask);
   endtask

   // -------------------------------------------------------------------------
   // Stimulus
   // -------------------------------------------------------------------------
   initial
   begin
      logic [3:0] mask;
      int         cycles;
      sync_rst_n   = 1'b0;
      ctl0         = '0;
      ddr_is_ready = '0;
      flr_assert   = 1'b0;
      void'($urandom(32'h5514));
      repeat (10) @(posedge clk);
      sync_rst_n <= 1'b1;

      repeat (12)
      begin
         @(posedge clk);
         ddr_is_ready <= 4'($urandom);
      end

      repeat (4)
      begin
         mask = 4'($urandom_range(1, 15));
         @(posedge clk);
         ctl0 <= {28'd0, mask};
         wait_done_flags(mask, cycles);
         if (cycles != DONE_WAIT)
         begin
            fail_run($sformatf("Done flags rose after %0d cycles instead of %0d",
                               cycles, DONE_WAIT));
         end
         @(posedge clk);
         ctl0 <= '0;
         wait_done_flags(4'd0, cycles);
      end

      // Every select value with all channels scrubbed
      for (int sel = 0; sel < 8; sel++)
      begin
         @(posedge clk);
         ctl0 <= {1'b1, 3'(sel), 24'd0, 4'hf};
         wait_done_flags(4'hf, cycles);
         check_value("id0", id0, 64'h1c00);
         check_value("id1", id1, 64'h0);
         @(posedge clk);
         ctl0 <= '0;
         wait_done_flags(4'd0, cycles);
      end

      // Staggered enables and aborts in debug mode
      repeat (8)
      begin
         @(posedge clk);
         ctl0 <= {1'b1, 3'($urandom), 24'd0, 4'($urandom_range(1, 15))};
         repeat ($urandom_range(2, 14)) @(posedge clk);
         ctl0[3:0] <= 4'($urandom);
         repeat (14) @(posedge clk);
         ctl0 <= '0;
         repeat (3) @(posedge clk);
      end

      repeat (6)
      begin
         @(posedge clk);
         flr_assert <= 1'b1;
         repeat ($urandom_range(1, 10)) @(posedge clk);
         flr_assert <= 1'b0;
         repeat (4) @(posedge clk);
      end

      repeat (4) @(posedge clk);
      if (u_dut.u_checker.fail_cnt == 0)
      begin
         $display("Simulation PASSED");
         $finish;
      end
      else
      begin
         fail_run("Assertion checker reported a protocol violation");
      end
   end

endmodule

// ==== cl_dram_scrb_checker.sv ====
`include "cl_dram_defines.svh"

module cl_dram_scrb_checker
(
   input logic        clk,
   input logic        sync_rst_n,
   input logic        flr_done,
   input logic        flr_q,
   input logic        dbg_en,
   input logic [31:0] status0,
   input logic [31:0] status1
);

   import cl_dram_pkg::*;

   int fail_cnt = 0;

   // State fields of the debug status word, channel 3 in the top nibble
   logic [3:0][2:0] dbg_state;

   assign dbg_state = {status0[30:28], status0[26:24], status0[22:20], status0[18:16]};

   // --------------------------------------------------------------------------
   // FLR response
   // --------------------------------------------------------------------------
   a_flr_single: assert property (@(posedge clk) disable iff (!sync_rst_n)
      flr_done |=> !flr_done)
      else begin $error("flr_done held high for two cycles"); fail_cnt++; end

   a_flr_req: assert property (@(posedge clk) disable iff (!sync_rst_n)
      !flr_q |=> !flr_done)
      else begin $error("flr_done high without a sampled request"); fail_cnt++; end

   a_version: assert property (@(posedge clk) disable iff (!sync_rst_n)
      status1 == `CL_VERSION)
      else begin $error("status1 differs from the version word"); fail_cnt++; end

   // status0 follows the debug enable by one cycle
   a_dbg_state: assert property (@(posedge clk) disable iff (!sync_rst_n)
      $past(dbg_en) |-> (dbg_state[0] <= SCRB_DONE && dbg_state[1] <= SCRB_DONE &&
                         dbg_state[2] <= SCRB_DONE && dbg_state[3] <= SCRB_DONE))
      else begin $error("Scrub state above done in debug status"); fail_cnt++; end

endmodule

bind cl_dram_scrb_top cl_dram_scrb_checker u_checker
(
   .clk        (clk),
   .sync_rst_n (sync_rst_n),
   .flr_done   (flr_done),
   .flr_q      (u_ctl.flr_q),
   .dbg_en     (ctl.dbg_en),
   .status0    (status0),
   .status1    (status1)
);

// ==== cl_dram_scrb_top.sv ====
`include "cl_dram_defines.svh"

module cl_dram_scrb_top
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  logic [31:0]            ctl0,
   input  cl_dram_pkg::ddr_mask_t ddr_is_ready,
   input  logic                   flr_assert,
   output logic [31:0]            status0,
   output logic [31:0]            status1,
   output logic [31:0]            id0,
   output logic [31:0]            id1,
   output logic                   flr_done
);

   cl_dram_pkg::scrb_ctl_t                  ctl;
   cl_dram_pkg::ddr_mask_t                  ddr_ready;
   cl_dram_pkg::scrb_stat_t [`NUM_DDR-1:0]  scrb;

   cl_scrb_ctl u_ctl
   (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .ctl          (ctl),
      .ddr_ready    (ddr_ready),
      .flr_done     (flr_done)
   );

   // --------------------------------------------------------------------------
   // One scrubber per channel, index order A, B, D, C
   // --------------------------------------------------------------------------
   for (genvar i = 0; i < `NUM_DDR; i++)
   begin : g_scrb
      ddr_scrubber
      #(
         .MAX_ADDR         (`SCRB_MAX_ADDR),
         .BURST_LEN_MINUS1 (`SCRB_BURST_LEN_MINUS1)
      )
      u_scrb
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .enable     (ctl.en[i]),
         .stat       (scrb[i])
      );
   end

   cl_scrb_status u_status
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl        (ctl),
      .ddr_ready  (ddr_ready),
      .scrb       (scrb),
      .status0    (status0),
      .status1    (status1),
      .id0        (id0),
      .id1        (id1)
   );

endmodule

// ==== cl_scrb_status.sv ====
`include "cl_dram_defines.svh"

module cl_scrb_status
(
   input  logic                                 clk,
   input  logic                                 sync_rst_n,
   input  cl_dram_pkg::scrb_ctl_t               ctl,
   input  cl_dram_pkg::ddr_mask_t               ddr_ready,
   input  cl_dram_pkg::scrb_stat_t [`NUM_DDR-1:0] scrb,
   output logic [31:0]                          status0,
   output logic [31:0]                          status1,
   output logic [31:0]                          id0,
   output logic [31:0]                          id1
);

   import cl_dram_pkg::*;

   ddr_mask_t   done_vec;
   ddr_addr_t   sel_addr;
   logic [31:0] status0_d;

   always_comb
   begin
      for (int i = 0; i < `NUM_DDR; i++)
      begin
         done_vec[i] = scrb[i].done;
      end
   end

   // Debug address select, out of range values fall back to index 0
   always_comb
   begin
      case (ctl.dbg_sel)
         3'd1:    sel_addr = scrb[1].addr;
         3'd2:    sel_addr = scrb[2].addr;
         3'd3:    sel_addr = scrb[3].addr;
         default: sel_addr = scrb[0].addr;
      endcase
   end

   // --------------------------------------------------------------------------
   // Status word
   // --------------------------------------------------------------------------
   always_comb
   begin
      if (ctl.dbg_en)
      begin
         status0_d = {1'b0, scrb[3].state, 1'b0, scrb[2].state,
                      1'b0, scrb[1].state, 1'b0, scrb[0].state,
                      8'd0, done_vec, ddr_ready};
      end
      else
      begin
         status0_d = {20'ha1111, 4'd0, done_vec, ddr_ready};
      end
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         status0 <= '0;
         id0     <= '0;
         id1     <= '0;
      end
      else
      begin
         status0 <= status0_d;
         id0     <= ctl.dbg_en ? sel_addr[31:0]  : `CL_ID0;
         id1     <= ctl.dbg_en ? sel_addr[63:32] : `CL_ID1;
      end
   end

   assign status1 = `CL_VERSION;

endmodule

// ==== ddr_scrubber.sv ====
`include "cl_dram_defines.svh"

module ddr_scrubber
#(
   parameter cl_dram_pkg::ddr_addr_t MAX_ADDR         = `SCRB_MAX_ADDR,
   parameter int                     BURST_LEN_MINUS1 = `SCRB_BURST_LEN_MINUS1
)
(
   input  logic                    clk,
   input  logic                    sync_rst_n,
   input  logic                    enable,
   output cl_dram_pkg::scrb_stat_t stat
);

   import cl_dram_pkg::*;

   localparam int        BEAT_BYTES = 64;
   localparam ddr_addr_t BURST_STEP = ddr_addr_t'((BURST_LEN_MINUS1 + 1) * BEAT_BYTES);

   scrb_state_t state_q;
   ddr_addr_t   addr_q;
   ddr_addr_t   next_addr;
   logic        done_q;

   assign next_addr = addr_q + BURST_STEP;

   // --------------------------------------------------------------------------
   // Scrub FSM and burst address walk
   // --------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state_q <= SCRB_IDLE;
         addr_q  <= '0;
         done_q  <= 1'b0;
      end
      else if (!enable)
      begin
         // Dropping the enable aborts or clears a finished scrub
         state_q <= SCRB_IDLE;
         addr_q  <= '0;
         done_q  <= 1'b0;
      end
      else
      begin
         case (state_q)
            SCRB_IDLE:
            begin
               state_q <= SCRB_RUN;
               addr_q  <= '0;
            end
            SCRB_RUN:
            begin
               if (next_addr > MAX_ADDR)
               begin
                  state_q <= SCRB_DONE;
                  done_q  <= 1'b1;
               end
               else
               begin
                  addr_q <= next_addr;
               end
            end
            SCRB_DONE:
            begin
               // Hold the last burst address until the enable drops
               state_q <= SCRB_DONE;
            end
            default:
            begin
               state_q <= SCRB_IDLE;
               addr_q  <= '0;
               done_q  <= 1'b0;
            end
         endcase
      end
   end

   assign stat = '{state: state_q, addr: addr_q, done: done_q};

endmodule

// ==== cl_scrb_ctl.sv ====
`include "cl_dram_defines.svh"

module cl_scrb_ctl
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  logic [31:0]            ctl0,
   input  cl_dram_pkg::ddr_mask_t ddr_is_ready,
   input  logic                   flr_assert,
   output cl_dram_pkg::scrb_ctl_t ctl,
   output cl_dram_pkg::ddr_mask_t ddr_ready,
   output logic                   flr_done
);

   import cl_dram_pkg::*;

   scrb_ctl_t ctl_d;
   logic      flr_q;

   // --------------------------------------------------------------------------
   // Control word decode
   // --------------------------------------------------------------------------
   // Bit 31 debug enable, bits 30:28 debug memory select,
   // bits 3:0 scrub enables in channel index order
   always_comb
   begin
      ctl_d.dbg_en  = ctl0[31];
      ctl_d.dbg_sel = ctl0[30:28];
      ctl_d.en      = ctl0[`NUM_DDR-1:0];
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl       <= '0;
         ddr_ready <= '0;
      end
      else
      begin
         ctl       <= ctl_d;
         ddr_ready <= ddr_is_ready;
      end
   end

   // --------------------------------------------------------------------------
   // FLR response
   // --------------------------------------------------------------------------
   // Pulses every other cycle while the request is held
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_q    <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_q    <= flr_assert;
         flr_done <= flr_q && !flr_done;
      end
   end

endmodule

// ==== cl_dram_pkg.sv ====
`include "cl_dram_defines.svh"

package cl_dram_pkg;

   // Byte address into one DDR channel
   typedef logic [63:0] ddr_addr_t;

   // One bit per channel index
   typedef logic [`NUM_DDR-1:0] ddr_mask_t;

   // -------------------------------------------------------------------------
   // Scrubber state and per-channel status
   // -------------------------------------------------------------------------
   typedef enum logic [2:0]
   {
      SCRB_IDLE = 3'd0,
      SCRB_RUN  = 3'd1,
      SCRB_DONE = 3'd2
   } scrb_state_t;

   typedef struct packed
   {
      scrb_state_t state;
      ddr_addr_t   addr;
      logic        done;
   } scrb_stat_t;

   // -------------------------------------------------------------------------
   // Decoded control word
   // -------------------------------------------------------------------------
   typedef struct packed
   {
      logic       dbg_en;
      logic [2:0] dbg_sel;
      ddr_mask_t  en;
   } scrb_ctl_t;

endpackage

// ==== cl_dram_defines.svh ====
`ifndef CL_DRAM_DEFINES_SVH
`define CL_DRAM_DEFINES_SVH

// Fixed readout values
`define CL_VERSION 32'hee_ee_ee_00
`define CL_ID0     32'h1d50_6789
`define CL_ID1     32'h1d51_fedc

// Last byte covered by each scrubber
`define SCRB_MAX_ADDR 64'h0000_0000_0000_1FFF

// Beats per scrub burst minus one, 64-byte beats
`define SCRB_BURST_LEN_MINUS1 15

// Channel index order is A, B, D, C
`define NUM_DDR 4

`endif
